/* hw/video_pkg.sv */
package video_pkg;

	////////////////////
	// Table geometry
	////////////////////

	// 256 indices per bank, two banks
	localparam int PIX_W      = 8;
	localparam int CLUT_DEPTH = 512;

	// Index from the tile/sprite mixer
	typedef logic [PIX_W-1:0] pix_index_t;

	// Bank bit on top of the pixel index
	typedef logic [PIX_W:0] clut_addr_t;

	// One colour gun, 4 bits
	typedef logic [3:0] color4_t;

	////////////////////
	// PROM words
	////////////////////

	// Red/green PROM byte
	// Stored raw, split into nibbles at the video stage
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			color4_t green;
			color4_t red;
		} nib;
	} rg_word_u;

	// Whole palette entry as the host sees it
	// Blue comes from the second, 4-bit PROM
	typedef struct packed {
		color4_t blue;
		color4_t green;
		color4_t red;
	} clut_entry_t;

endpackage

/* hw/bus_pkg.sv */
package bus_pkg;

	////////////////////
	// AXI4-Lite widths
	////////////////////

	localparam int AXIL_ADDR_W = 12;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	// Response codes, only two in use
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	////////////////////
	// CLUT register map
	////////////////////

	// One 32-bit word per entry
	localparam int ENTRY_LSB = 2;

	// First byte address past the table
	localparam logic [AXIL_ADDR_W-1:0] CLUT_LIMIT = 12'h800;

	// Field positions inside the data word
	// Bits above 11 are dropped on write, zero on read
	localparam int RED_LSB   = 0;
	localparam int GREEN_LSB = 4;
	localparam int BLUE_LSB  = 8;

endpackage

/* hw/clut_wr_if.sv */
// Host side access to the palette RAMs
interface clut_wr_if;
	import video_pkg::*;

	// Entry number, bank bit on top
	clut_addr_t  addr;

	// Write strobe, taken at the clock edge
	logic        we;

	// Entry to store
	clut_entry_t wdata;

	// Entry at addr, one cycle after addr
	clut_entry_t rdata;

	// Bus slave side
	modport bus (
		output addr,
		output we,
		output wdata,
		input  rdata
	);

	// Memory side
	modport mem (
		input  addr,
		input  we,
		input  wdata,
		output rdata
	);

endinterface

/* hw/clut_ram.sv */
module clut_ram (
	input  logic                  clk_6md,
	input  logic                  rst,
	clut_wr_if.mem                bus,
	input  video_pkg::clut_addr_t vid_addr,
	output video_pkg::rg_word_u   vid_rg,
	output video_pkg::color4_t    vid_b
);
	import video_pkg::*;

	// Red/green PROM and blue PROM
	rg_word_u   rg_mem [CLUT_DEPTH];
	color4_t    b_mem  [CLUT_DEPTH];

	// Clear sweep after reset
	logic       sweeping;
	clut_addr_t sweep_addr;

	// Shared write port
	logic       wr_en;
	clut_addr_t wr_addr;
	rg_word_u   wr_rg;
	color4_t    wr_b;

	// Bus side read register
	rg_word_u   bus_rg;
	color4_t    bus_b;

	////////////////////
	// Reset sweep
	////////////////////

	// Walks every entry once, host writes wait for the end
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			sweeping   <= 1'b1;
			sweep_addr <= '0;
		end else if (sweeping) begin
			sweep_addr <= sweep_addr + 1'b1;
			if (&sweep_addr)
				sweeping <= 1'b0;
		end
	end

	// Sweep owns the port while running
	always_comb begin
		wr_rg.nib.green = bus.wdata.green;
		wr_rg.nib.red   = bus.wdata.red;
		wr_b            = bus.wdata.blue;
		wr_en           = bus.we;
		wr_addr         = bus.addr;
		if (sweeping) begin
			wr_rg.raw = '0;
			wr_b      = '0;
			wr_en     = 1'b1;
			wr_addr   = sweep_addr;
		end
	end

	////////////////////
	// Arrays
	////////////////////

	// Both read ports see the old word on a same-entry write
	always_ff @(posedge clk_6md) begin
		if (wr_en) begin
			rg_mem[wr_addr] <= wr_rg;
			b_mem[wr_addr]  <= wr_b;
		end
		bus_rg <= rg_mem[bus.addr];
		bus_b  <= b_mem[bus.addr];
	end

	// Video port, stands in for the LS173 output latches
	always_ff @(posedge clk_6md) begin
		vid_rg <= rg_mem[vid_addr];
		vid_b  <= b_mem[vid_addr];
	end

	// Rejoin the two PROM words for the host
	assign bus.rdata = {bus_b, bus_rg.nib.green, bus_rg.nib.red};

endmodule

/* hw/clut_axil_slave.sv */
module clut_axil_slave (
	input  logic                            clk_6md,
	input  logic                            rst,
	// Write address and data
	input  logic [bus_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [bus_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [bus_pkg::AXIL_STRB_W-1:0] wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	// Write response
	output bus_pkg::resp_t                  bresp,
	output logic                            bvalid,
	input  logic                            bready,
	// Read address
	input  logic [bus_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	// Read data
	output logic [bus_pkg::AXIL_DATA_W-1:0] rdata,
	output bus_pkg::resp_t                  rresp,
	output logic                            rvalid,
	input  logic                            rready,
	// Palette RAM
	clut_wr_if.bus                          mem
);
	import bus_pkg::*;
	import video_pkg::*;

	// Write side
	logic                   wr_fire;
	logic                   wr_hit;
	logic                   wr_go;
	clut_addr_t             wr_addr;

	// Read side
	logic                   rd_fire;
	logic                   rd_go;
	logic                   rd_pend;
	logic                   rd_issued;
	logic                   rd_err;
	clut_addr_t             rd_addr;
	logic [AXIL_DATA_W-1:0] rd_word;

	////////////////////
	// Write channel
	////////////////////

	// Address and data taken together, never with a response pending
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;

	assign wr_hit  = awaddr < CLUT_LIMIT;
	assign wr_addr = awaddr[ENTRY_LSB +: $bits(clut_addr_t)];

	// Out of range writes never reach the RAM
	assign wr_go   = wr_fire && wr_hit;

	// Entry spans lanes 0 and 1, so partial strobes still write it all
	assign mem.wdata = {wdata[BLUE_LSB +: $bits(color4_t)],
		wdata[GREEN_LSB +: $bits(color4_t)],
		wdata[RED_LSB +: $bits(color4_t)]};
	assign mem.we    = wr_go;

	// One response slot
	always_ff @(posedge clk_6md) begin
		if (rst)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk_6md) begin
		if (wr_fire)
			bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
	end

	////////////////////
	// Read channel
	////////////////////

	// Single slot from address to data
	assign arready = !(rd_pend || rd_issued || rvalid);
	assign rd_fire = arvalid && arready;

	// Write takes the RAM address first
	assign rd_go    = rd_pend && !wr_go;
	assign mem.addr = wr_go ? wr_addr : rd_addr;

	// Entry back into register layout
	always_comb begin
		rd_word = '0;
		rd_word[RED_LSB +: $bits(color4_t)]   = mem.rdata.red;
		rd_word[GREEN_LSB +: $bits(color4_t)] = mem.rdata.green;
		rd_word[BLUE_LSB +: $bits(color4_t)]  = mem.rdata.blue;
	end

	always_ff @(posedge clk_6md) begin
		if (rst) begin
			rd_pend   <= 1'b0;
			rd_issued <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			if (rd_fire)
				rd_pend <= 1'b1;
			else if (rd_go)
				rd_pend <= 1'b0;
			// RAM word valid the cycle after issue
			rd_issued <= rd_go;
			if (rd_issued)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Address and status held for the whole slot
	always_ff @(posedge clk_6md) begin
		if (rd_fire) begin
			rd_addr <= araddr[ENTRY_LSB +: $bits(clut_addr_t)];
			rd_err  <= araddr >= CLUT_LIMIT;
		end
		if (rd_issued) begin
			rdata <= rd_err ? '0 : rd_word;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

/* hw/videogen_subsystem.sv */
module videogen_subsystem (
	input  logic                  clk_6md,
	input  logic                  rst,
	// From the tile/sprite mixer
	input  video_pkg::pix_index_t pix,
	input  logic                  bank,
	input  logic                  sync_in,
	// CLUT video port
	output video_pkg::clut_addr_t clut_addr,
	input  video_pkg::rg_word_u   clut_rg,
	input  video_pkg::color4_t    clut_b,
	// To the monitor
	output logic                  sync,
	output video_pkg::color4_t    red,
	output video_pkg::color4_t    green,
	output video_pkg::color4_t    blue
);
	import video_pkg::*;

	// Index latch, LS273 on the board
	pix_index_t pix_q;
	logic       bank_q;

	// First sync stage
	logic       sync_q;

	////////////////////
	// Index latch
	////////////////////

	always_ff @(posedge clk_6md) begin
		if (rst) begin
			pix_q  <= '0;
			bank_q <= 1'b0;
		end else begin
			pix_q  <= pix;
			bank_q <= bank;
		end
	end

	// Bank selects the upper half of both PROMs
	assign clut_addr = {bank_q, pix_q};

	////////////////////
	// Colour out
	////////////////////

	// Red/green byte split by nibble view
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else begin
			red   <= clut_rg.nib.red;
			green <= clut_rg.nib.green;
			blue  <= clut_b;
		end
	end

	// Sync delay, two stages
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			sync_q <= 1'b0;
			sync   <= 1'b0;
		end else begin
			sync_q <= sync_in;
			sync   <= sync_q;
		end
	end

endmodule

/* hw/clut_top.sv */
module clut_top (
	input  logic                            clk_6md,
	input  logic                            rst,
	// AXI4-Lite host port
	input  logic [bus_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [bus_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [bus_pkg::AXIL_STRB_W-1:0] wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output bus_pkg::resp_t                  bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [bus_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [bus_pkg::AXIL_DATA_W-1:0] rdata,
	output bus_pkg::resp_t                  rresp,
	output logic                            rvalid,
	input  logic                            rready,
	// Video
	input  video_pkg::pix_index_t           pix,
	input  logic                            bank,
	input  logic                            sync_in,
	output logic                            sync,
	output video_pkg::color4_t              red,
	output video_pkg::color4_t              green,
	output video_pkg::color4_t              blue
);
	import video_pkg::*;

	// Video port between RAM and colour stage
	clut_addr_t vid_addr;
	rg_word_u   vid_rg;
	color4_t    vid_b;

	// Host access to the palette
	clut_wr_if clut_bus ();

	clut_axil_slave u_slave (
		.clk_6md (clk_6md),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.mem     (clut_bus.bus)
	);

	// Both palette PROMs
	clut_ram u_ram (
		.clk_6md  (clk_6md),
		.rst      (rst),
		.bus      (clut_bus.mem),
		.vid_addr (vid_addr),
		.vid_rg   (vid_rg),
		.vid_b    (vid_b)
	);

	videogen_subsystem u_video (
		.clk_6md   (clk_6md),
		.rst       (rst),
		.pix       (pix),
		.bank      (bank),
		.sync_in   (sync_in),
		.clut_addr (vid_addr),
		.clut_rg   (vid_rg),
		.clut_b    (vid_b),
		.sync      (sync),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

/* verif/tb_clut_top.sv */
module tb_clut_top;
	import video_pkg::*;
	import bus_pkg::*;

	// Sweep plus 8 reset cycles, ~2 cycles per write, ~5 per read, 1000 pixels, sync run
	localparam int CYCLE_LIMIT = 5000;

	logic                   clk_6md;
	logic                   rst;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic [AXIL_STRB_W-1:0] wstrb;
	logic                   wvalid;
	logic                   wready;
	resp_t                  bresp;
	logic                   bvalid;
	logic                   bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   arvalid;
	logic                   arready;
	logic [AXIL_DATA_W-1:0] rdata;
	resp_t                  rresp;
	logic                   rvalid;
	logic                   rready;
	pix_index_t             pix;
	logic                   bank;
	logic                   sync_in;
	logic                   sync;
	color4_t                red;
	color4_t                green;
	color4_t                blue;

	// Reference palette, {blue, green, red}
	logic [11:0]            model [CLUT_DEPTH];

	// Expected responses for the transfer in flight
	resp_t                  wr_exp_resp;
	resp_t                  rd_exp_resp;
	logic [AXIL_DATA_W-1:0] rd_exp;

	// Expected colour, three stages deep
	logic [11:0]            exp_c [3];
	logic                   exp_v [3];
	logic                   stream_on;

	integer                 seed;
	int                     cycles;
	int                     errors;
	int                     errs_at_start;
	int                     pass_cnt;
	int                     fail_cnt;

	clut_top u_dut (
		.clk_6md (clk_6md),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.pix     (pix),
		.bank    (bank),
		.sync_in (sync_in),
		.sync    (sync),
		.red     (red),
		.green   (green),
		.blue    (blue)
	);

	////////////////////
	// Clock and watchdog
	////////////////////

	always #50 clk_6md = ~clk_6md;

	always @(posedge clk_6md) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// Colour the DUT should show three edges later
	always @(posedge clk_6md) begin
		exp_c[0] <= model[{bank, pix}];
		exp_v[0] <= stream_on;
		exp_c[1] <= exp_c[0];
		exp_v[1] <= exp_v[0];
		exp_c[2] <= exp_c[1];
		exp_v[2] <= exp_v[1];
	end

	////////////////////
	// Assertions
	////////////////////

	// Reset values, all zero except arready
	a_reset: assert property (@(posedge clk_6md) $past(rst) |->
		red == 0 && green == 0 && blue == 0 && sync == 0 &&
		!bvalid && !rvalid && arready)
	else begin
		errors++;
		$display("[ERROR] %0t {red,green,blue,sync,bvalid,rvalid,arready}: expected %h, got %h",
			$time, 16'h0001, {$sampled(red), $sampled(green), $sampled(blue),
			$sampled(sync), $sampled(bvalid), $sampled(rvalid), $sampled(arready)});
	end

	a_bresp: assert property (@(posedge clk_6md) disable iff (rst)
		bvalid && bready |-> bresp == wr_exp_resp)
	else begin
		errors++;
		$display("[ERROR] %0t bresp: expected %h, got %h",
			$time, $sampled(wr_exp_resp), $sampled(bresp));
	end

	a_rdata: assert property (@(posedge clk_6md) disable iff (rst)
		rvalid && rready |-> rdata == rd_exp)
	else begin
		errors++;
		$display("[ERROR] %0t rdata: expected %h, got %h",
			$time, $sampled(rd_exp), $sampled(rdata));
	end

	a_rresp: assert property (@(posedge clk_6md) disable iff (rst)
		rvalid && rready |-> rresp == rd_exp_resp)
	else begin
		errors++;
		$display("[ERROR] %0t rresp: expected %h, got %h",
			$time, $sampled(rd_exp_resp), $sampled(rresp));
	end

	// Held response blocks the write channel
	a_bhold: assert property (@(posedge clk_6md) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		errors++;
		$display("Write response dropped or changed at %0t while bready was low", $time);
	end

	a_wblock: assert property (@(posedge clk_6md) disable iff (rst)
		bvalid |-> !awready && !wready)
	else begin
		errors++;
		$display("[ERROR] %0t awready/wready: expected 0/0, got %b/%b",
			$time, $sampled(awready), $sampled(wready));
	end

	a_rhold: assert property (@(posedge clk_6md) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else begin
		errors++;
		$display("Read data dropped or changed at %0t while rready was low", $time);
	end

	a_colour: assert property (@(posedge clk_6md) disable iff (rst)
		exp_v[2] |-> {blue, green, red} == exp_c[2])
	else begin
		errors++;
		$display("[ERROR] %0t {blue,green,red}: expected %h, got %h", $time,
			$sampled(exp_c[2]), {$sampled(blue), $sampled(green), $sampled(red)});
	end

	a_sync: assert property (@(posedge clk_6md) disable iff (rst)
		cycles > 12 |-> sync == $past(sync_in, 2))
	else begin
		errors++;
		$display("[ERROR] %0t sync: expected %b, got %b",
			$time, $past(sync_in, 2), $sampled(sync));
	end

	////////////////////
	// Bus tasks
	////////////////////

	// hold = cycles with bready low once bvalid is up
	task automatic bus_write(input logic [11:0] a, input logic [31:0] d,
		input logic [3:0] s, input int hold);
		begin
			@(negedge clk_6md);
			awaddr      = a;
			wdata       = d;
			wstrb       = s;
			awvalid     = 1'b1;
			wvalid      = 1'b1;
			bready      = (hold == 0);
			wr_exp_resp = (a < 12'h800) ? RESP_OKAY : RESP_SLVERR;
			#1;
			while (!awready) begin
				@(negedge clk_6md);
				#1;
			end
			@(posedge clk_6md);
			// Only in-range writes land in the table
			if (a < 12'h800)
				model[a[10:2]] = d[11:0];
			@(negedge clk_6md);
			awvalid = 1'b0;
			wvalid  = 1'b0;
			while (!bvalid)
				@(negedge clk_6md);
			// Same write offered again while the response is held
			if (hold > 0) begin
				awvalid = 1'b1;
				wvalid  = 1'b1;
			end
			repeat (hold) @(negedge clk_6md);
			awvalid = 1'b0;
			wvalid  = 1'b0;
			bready  = 1'b1;
			@(posedge clk_6md);
		end
	endtask

	task automatic bus_read(input logic [11:0] a, input int hold);
		begin
			@(negedge clk_6md);
			araddr      = a;
			arvalid     = 1'b1;
			rready      = (hold == 0);
			rd_exp_resp = (a < 12'h800) ? RESP_OKAY : RESP_SLVERR;
			rd_exp      = (a < 12'h800) ? {20'd0, model[a[10:2]]} : 32'd0;
			#1;
			while (!arready) begin
				@(negedge clk_6md);
				#1;
			end
			@(posedge clk_6md);
			@(negedge clk_6md);
			arvalid = 1'b0;
			while (!rvalid)
				@(negedge clk_6md);
			// Neighbour entry offered while the data is held
			if (hold > 0) begin
				araddr  = a ^ 12'h004;
				arvalid = 1'b1;
			end
			repeat (hold) @(negedge clk_6md);
			arvalid = 1'b0;
			rready  = 1'b1;
			@(posedge clk_6md);
		end
	endtask

	task automatic report_test(input string name);
		begin
			if (errors == errs_at_start) begin
				pass_cnt++;
				$display("Test %s: pass", name);
			end else begin
				fail_cnt++;
				$display("Test %s: fail, %0d errors", name, errors - errs_at_start);
			end
			errs_at_start = errors;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		clk_6md   = 1'b0;
		rst       = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b1;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b1;
		pix       = '0;
		bank      = 1'b0;
		sync_in   = 1'b0;
		stream_on = 1'b0;
		seed      = 79721;
		cycles    = 0;
		errors    = 0;
		errs_at_start = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		for (int i = 0; i < CLUT_DEPTH; i++)
			model[i] = '0;

		repeat (8) @(posedge clk_6md);
		@(negedge clk_6md);
		rst = 1'b0;
		// RAM clear sweep runs 512 cycles
		repeat (520) @(negedge clk_6md);
		report_test("reset");

		// Random entries, random upper bits and strobes
		for (int i = 0; i < 32; i++) begin
			logic [11:0] a;
			a = {1'b0, 9'($random(seed)), 2'b00};
			bus_write(a, $random(seed), 4'($random(seed)), 0);
			bus_read(a, 0);
		end
		report_test("round_trip");

		bus_write(12'h7FC, 32'hFFFF_0A5C, 4'hF, 0);
		bus_write(12'h800, 32'h0000_0123, 4'hF, 0);
		bus_write(12'hFFC, 32'h0000_0456, 4'hF, 0);
		bus_read(12'h800, 0);
		bus_read(12'hFFC, 0);
		bus_read(12'h7FC, 0);
		report_test("range");

		bus_write(12'h010, 32'h0000_0987, 4'hF, 6);
		bus_read(12'h010, 6);
		report_test("back_pressure");

		// Whole table, then a random pixel stream
		for (int i = 0; i < CLUT_DEPTH; i++)
			bus_write(12'(i * 4), $random(seed), 4'hF, 0);
		@(negedge clk_6md);
		stream_on = 1'b1;
		for (int i = 0; i < 1000; i++) begin
			pix  = 8'($random(seed));
			bank = 1'($random(seed));
			@(negedge clk_6md);
		end
		stream_on = 1'b0;
		repeat (4) @(negedge clk_6md);
		report_test("colour_path");

		// Random sync level every cycle
		for (int i = 0; i < 64; i++) begin
			sync_in = 1'($random(seed));
			@(negedge clk_6md);
		end
		sync_in = 1'b0;
		repeat (4) @(negedge clk_6md);
		report_test("sync_align");

		$display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* all.f */
hw/video_pkg.sv
hw/bus_pkg.sv
hw/clut_wr_if.sv
hw/clut_ram.sv
hw/clut_axil_slave.sv
hw/videogen_subsystem.sv
hw/clut_top.sv
verif/tb_clut_top.sv

/* Makefile */
# Verilator build for the CLUT colour stage

TOP = tb_clut_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove obj_dir"

obj_dir/V$(TOP): all.f
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
